// File: logic/cpc_pkg.sv
package cpc_pkg;

  // ====================
  // Bus and video types
  // ====================
  typedef logic [7:0]  data_t;       // CPU data byte
  typedef logic [15:0] addr_t;       // CPU address
  typedef logic [4:0]  color_t;      // Hardware colour number
  typedef logic [3:0]  pen_t;        // Pen index into palette
  typedef logic [1:0]  video_mode_t; // Screen mode
  typedef logic [9:0]  scr_start_t;  // CRTC screen start, regs 12/13

  // Gate array command, data bits 7..6
  typedef enum logic [1:0] {
    GA_INK_SEL  = 2'd0, // Pen or border select
    GA_PALETTE  = 2'd1, // Colour into selected entry
    GA_MODE_ROM = 2'd2, // ROM disables and mode
    GA_RAM_CFG  = 2'd3  // RAM banking, not kept
  } ga_cmd_e;

  // Host address bits 23..16
  typedef enum logic [7:0] {
    REGION_RAM  = 8'h00,
    REGION_ROM  = 8'h01,
    REGION_CTRL = 8'hFF  // Control register
  } host_region_e;

  // Owner of the memory write port
  typedef enum logic {
    GRANT_CPU  = 1'b0,
    GRANT_HOST = 1'b1
  } grant_e;

  // ====================
  // IO address high bytes
  // ====================
  localparam data_t PPI_A_HI    = 8'hF4;
  localparam data_t PPI_B_HI    = 8'hF5; // Read only here
  localparam data_t PPI_C_HI    = 8'hF6;
  localparam data_t PPI_CTRL_HI = 8'hF7;
  localparam data_t CRTC_SEL_HI  = 8'hBC; // Register index
  localparam data_t CRTC_DATA_HI = 8'hBD; // Register data

  // CRTC register numbers
  localparam logic [4:0] CRTC_START_HI_REG = 5'd12;
  localparam logic [4:0] CRTC_START_LO_REG = 5'd13;

endpackage

// File: logic/gate_array.sv
module gate_array #(
  parameter int unsigned c_basic_rom_bank = 7 // ROM select that maps BASIC bank
) (
  input  logic                clk_cpu,
  input  logic                pwr_up_reset_n,
  input  cpc_pkg::addr_t      i_addr,
  input  cpc_pkg::data_t      i_data,
  input  logic                i_iowr_n,
  input  cpc_pkg::pen_t       i_pen_lookup,
  output cpc_pkg::color_t     o_color,
  output cpc_pkg::color_t     o_border,
  output cpc_pkg::video_mode_t o_mode,
  output logic                o_lo_rom_dis,
  output logic                o_hi_rom_dis,
  output logic [1:0]          o_upper_bank,
  output cpc_pkg::data_t      o_rom_sel
);

  cpc_pkg::ga_cmd_e ga_cmd;
  cpc_pkg::color_t  palette [16]; // One colour per pen
  cpc_pkg::pen_t    pen;          // Pen targeted by palette writes
  logic             border_sel;   // Palette writes go to border
  logic             ga_wr;
  logic             rom_sel_wr;

  // ====================
  // Decode
  // ====================
  assign ga_cmd     = cpc_pkg::ga_cmd_e'(i_data[7:6]);
  assign ga_wr      = !i_iowr_n && (i_addr[15:14] == 2'b01);
  // ROM select sits below the gate array range, bit 13 low
  assign rom_sel_wr = !i_iowr_n && (i_addr[15:14] != 2'b01) && !i_addr[13];

  // ====================
  // Registers
  // ====================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      pen          <= '0;
      border_sel   <= 1'b0;
      o_border     <= '0;
      o_mode       <= '0;  // Mode 0
      o_lo_rom_dis <= 1'b0; // Both ROMs enabled
      o_hi_rom_dis <= 1'b0;
      o_rom_sel    <= '0;
      for (int i = 0; i < 16; i++) begin
        palette[i] <= '0;
      end
    end else if (ga_wr) begin
      case (ga_cmd)
        cpc_pkg::GA_INK_SEL: begin
          border_sel <= i_data[4];
          if (!i_data[4]) pen <= i_data[3:0]; // Keep pen when border picked
        end
        cpc_pkg::GA_PALETTE: begin
          if (border_sel) o_border <= i_data[4:0];
          else palette[pen] <= i_data[4:0];
        end
        cpc_pkg::GA_MODE_ROM: begin
          o_hi_rom_dis <= i_data[3];
          o_lo_rom_dis <= i_data[2];
          o_mode       <= i_data[1:0];
        end
        cpc_pkg::GA_RAM_CFG: ; // No RAM banking in this core
        default: ;
      endcase
    end else if (rom_sel_wr) begin
      o_rom_sel <= i_data;
    end
  end

  // Palette lookup for video side
  assign o_color = palette[i_pen_lookup];

  // Upper ROM is BASIC only for the matching select value
  assign o_upper_bank = (o_rom_sel == 8'(c_basic_rom_bank)) ? 2'd2 : 2'd1;

endmodule

// File: logic/io_ports.sv
module io_ports (
  input  logic                clk_cpu,
  input  logic                pwr_up_reset_n,
  input  cpc_pkg::addr_t      i_addr,
  input  cpc_pkg::data_t      i_data,
  input  logic                i_iowr_n,
  input  logic                i_vsync,
  output cpc_pkg::data_t      o_ppi_a,
  output cpc_pkg::data_t      o_ppi_c,
  output cpc_pkg::data_t      o_ppi_ctrl,
  output cpc_pkg::scr_start_t o_scr_start,
  output cpc_pkg::data_t      o_io_rdata
);

  logic [4:0] crtc_idx;    // Selected CRTC register

  // ====================
  // PPI and CRTC writes
  // ====================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      o_ppi_a     <= '0;
      o_ppi_c     <= '0;
      o_ppi_ctrl  <= '0;
      crtc_idx    <= '0;
      o_scr_start <= '0;
    end else if (!i_iowr_n) begin
      case (i_addr[15:8])
        cpc_pkg::PPI_A_HI:    o_ppi_a    <= i_data;
        cpc_pkg::PPI_C_HI:    o_ppi_c    <= i_data;
        cpc_pkg::PPI_CTRL_HI: o_ppi_ctrl <= i_data;
        cpc_pkg::CRTC_SEL_HI: crtc_idx   <= i_data[4:0];
        cpc_pkg::CRTC_DATA_HI: begin
          // Only screen start regs are kept
          if (crtc_idx == cpc_pkg::CRTC_START_HI_REG) o_scr_start[9:8] <= i_data[1:0];
          if (crtc_idx == cpc_pkg::CRTC_START_LO_REG) o_scr_start[7:0] <= i_data;
        end
        default: ;
      endcase
    end
  end

  // Port B read, vsync on bit 0 inverted
  always_comb begin
    o_io_rdata = '0;
    if (i_addr[15:8] == cpc_pkg::PPI_B_HI) begin
      o_io_rdata = 8'h1E | {7'd0, ~i_vsync};
    end
  end

endmodule

// File: logic/mem_arbiter.sv
module mem_arbiter (
  input  logic           clk_cpu,
  input  logic           pwr_up_reset_n,
  input  logic           i_host_wr,
  input  logic [23:0]    i_host_addr,
  input  cpc_pkg::data_t i_host_data,
  input  cpc_pkg::addr_t i_addr,
  input  cpc_pkg::data_t i_data,
  input  logic           i_memwr_n,
  output logic           o_mem_we,
  output logic           o_mem_to_rom,
  output cpc_pkg::addr_t o_mem_addr,
  output cpc_pkg::data_t o_mem_wdata,
  output logic           o_wait_n,
  output logic           o_cpu_reset_n
);

  cpc_pkg::data_t       ctrl;   // Bit 0 CPU reset, bit 1 load
  cpc_pkg::grant_e      grant;
  cpc_pkg::host_region_e region;
  logic                 ctrl_wr;

  assign region  = cpc_pkg::host_region_e'(i_host_addr[23:16]);
  assign ctrl_wr = i_host_wr && (region == cpc_pkg::REGION_CTRL);

  // ====================
  // Host control register
  // ====================
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) ctrl <= '0;
    else if (ctrl_wr) ctrl <= i_host_data;
  end

  assign grant         = ctrl[1] ? cpc_pkg::GRANT_HOST : cpc_pkg::GRANT_CPU;
  assign o_wait_n      = (grant == cpc_pkg::GRANT_CPU); // CPU stalls during load
  assign o_cpu_reset_n = pwr_up_reset_n && !ctrl[0];

  // ====================
  // Write port mux
  // ====================
  always_comb begin
    case (grant)
      cpc_pkg::GRANT_HOST: begin
        // CPU writes dropped here
        o_mem_we     = i_host_wr && ((region == cpc_pkg::REGION_RAM) ||
                                     (region == cpc_pkg::REGION_ROM));
        o_mem_to_rom = (region == cpc_pkg::REGION_ROM);
        o_mem_addr   = i_host_addr[15:0];
        o_mem_wdata  = i_host_data;
      end
      default: begin
        o_mem_we     = !i_memwr_n; // CPU only reaches RAM
        o_mem_to_rom = 1'b0;
        o_mem_addr   = i_addr;
        o_mem_wdata  = i_data;
      end
    endcase
  end

  // Host strobe lasts a single cycle
  a_host_pulse: assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    i_host_wr |=> !i_host_wr);

endmodule

// File: logic/memory_map.sv
module memory_map (
  input  logic           clk_cpu,
  input  logic           pwr_up_reset_n,
  input  logic           i_mem_we,
  input  logic           i_mem_to_rom,
  input  cpc_pkg::addr_t i_mem_addr,
  input  cpc_pkg::data_t i_mem_wdata,
  input  cpc_pkg::addr_t i_addr,
  input  logic           i_memrd_n,
  input  logic           i_iord_n,
  input  cpc_pkg::data_t i_io_rdata,
  input  logic           i_lo_rom_dis,
  input  logic           i_hi_rom_dis,
  input  logic [1:0]     i_upper_bank,
  output cpc_pkg::data_t o_data
);

  cpc_pkg::data_t ram [65536];
  cpc_pkg::data_t rom [65536]; // Four 16 KiB banks
  cpc_pkg::addr_t rom_addr;
  cpc_pkg::data_t ram_byte;
  cpc_pkg::data_t rom_byte;
  cpc_pkg::data_t mem_byte;

  // ====================
  // Shared write port
  // ====================
  always_ff @(posedge clk_cpu) begin
    if (i_mem_we) begin
      if (i_mem_to_rom) rom[i_mem_addr] <= i_mem_wdata;
      else ram[i_mem_addr] <= i_mem_wdata;
    end
  end

  // Lower ROM always bank 0, upper from ROM select
  assign rom_addr = (i_addr[15:14] == 2'b00) ? {2'b00, i_addr[13:0]}
                                             : {i_upper_bank, i_addr[13:0]};
  assign ram_byte = ram[i_addr];
  assign rom_byte = rom[rom_addr];

  // ====================
  // ROM map
  // ====================
  always_comb begin
    mem_byte = ram_byte; // Middle 32 KiB is RAM only
    case (i_addr[15:14])
      2'b00: if (!i_lo_rom_dis) mem_byte = rom_byte;
      2'b11: if (!i_hi_rom_dis) mem_byte = rom_byte;
      default: ;
    endcase
  end

  // Read byte, one cycle after strobes
  always_ff @(posedge clk_cpu) begin
    if (!pwr_up_reset_n) begin
      o_data <= '0;
    end else if (!i_memrd_n) begin
      o_data <= mem_byte;
    end else if (!i_iord_n) begin
      o_data <= i_io_rdata;
    end else begin
      o_data <= '0; // Idle bus reads 00
    end
  end

  // Bus never asserts both read kinds
  a_one_read: assert property (@(posedge clk_cpu) disable iff (!pwr_up_reset_n)
    !(!i_memrd_n && !i_iord_n));

endmodule

// File: logic/cpc_core.sv
module cpc_core #(
  parameter int unsigned c_basic_rom_bank = 7 // ROM select for BASIC in upper ROM
) (
  input  logic                 clk_cpu,
  input  logic                 pwr_up_reset_n,
  // CPU bus
  input  cpc_pkg::addr_t       i_addr,
  input  cpc_pkg::data_t       i_data,
  input  logic                 i_mreq_n,
  input  logic                 i_iorq_n,
  input  logic                 i_rd_n,
  input  logic                 i_wr_n,
  output cpc_pkg::data_t       o_data,
  output logic                 o_wait_n,
  output logic                 o_cpu_reset_n,
  // Host loader
  input  logic                 i_host_wr,
  input  logic [23:0]          i_host_addr,
  input  cpc_pkg::data_t       i_host_data,
  // Video side
  input  logic                 i_vsync,
  input  cpc_pkg::pen_t        i_pen_lookup,
  output cpc_pkg::color_t      o_color,
  output cpc_pkg::color_t      o_border,
  output cpc_pkg::video_mode_t o_mode,
  output cpc_pkg::data_t       o_ppi_a,
  output cpc_pkg::data_t       o_ppi_c,
  output cpc_pkg::data_t       o_ppi_ctrl,
  output cpc_pkg::scr_start_t  o_scr_start,
  output cpc_pkg::data_t       o_led
);

  // Combined strobes, active low
  logic iowr_n, memwr_n, iord_n, memrd_n;
  assign iowr_n  = i_iorq_n | i_wr_n;
  assign memwr_n = i_mreq_n | i_wr_n;
  assign iord_n  = i_iorq_n | i_rd_n;
  assign memrd_n = i_mreq_n | i_rd_n;

  logic           lo_rom_dis, hi_rom_dis;
  logic [1:0]     upper_bank;
  cpc_pkg::data_t io_rdata;
  logic           mem_we, mem_to_rom;
  cpc_pkg::addr_t mem_addr;
  cpc_pkg::data_t mem_wdata;

  // ====================
  // Peers
  // ====================
  gate_array #(.c_basic_rom_bank(c_basic_rom_bank)) u_ga (
    .clk_cpu, .pwr_up_reset_n, .i_addr, .i_data, .i_iowr_n(iowr_n),
    .i_pen_lookup, .o_color, .o_border, .o_mode,
    .o_lo_rom_dis(lo_rom_dis), .o_hi_rom_dis(hi_rom_dis),
    .o_upper_bank(upper_bank), .o_rom_sel(o_led) // ROM select shown on LEDs
  );

  io_ports u_io (
    .clk_cpu, .pwr_up_reset_n, .i_addr, .i_data, .i_iowr_n(iowr_n), .i_vsync,
    .o_ppi_a, .o_ppi_c, .o_ppi_ctrl, .o_scr_start, .o_io_rdata(io_rdata)
  );

  mem_arbiter u_arb (
    .clk_cpu, .pwr_up_reset_n, .i_host_wr, .i_host_addr, .i_host_data,
    .i_addr, .i_data, .i_memwr_n(memwr_n),
    .o_mem_we(mem_we), .o_mem_to_rom(mem_to_rom), .o_mem_addr(mem_addr),
    .o_mem_wdata(mem_wdata), .o_wait_n, .o_cpu_reset_n
  );

  memory_map u_mem (
    .clk_cpu, .pwr_up_reset_n,
    .i_mem_we(mem_we), .i_mem_to_rom(mem_to_rom), .i_mem_addr(mem_addr),
    .i_mem_wdata(mem_wdata), .i_addr, .i_memrd_n(memrd_n), .i_iord_n(iord_n),
    .i_io_rdata(io_rdata), .i_lo_rom_dis(lo_rom_dis), .i_hi_rom_dis(hi_rom_dis),
    .i_upper_bank(upper_bank), .o_data
  );

endmodule

// File: verif/cpc_model.svh
`ifndef CPC_MODEL_SVH
`define CPC_MODEL_SVH

// ====================
// Model state
// ====================
cpc_pkg::data_t       m_ram [65536];
cpc_pkg::data_t       m_rom [65536];  // Four 16 KiB banks
cpc_pkg::color_t      m_palette [16];
cpc_pkg::pen_t        m_pen;
logic                 m_border_sel;
cpc_pkg::color_t      m_border;
cpc_pkg::video_mode_t m_mode;
logic                 m_lo_dis;
logic                 m_hi_dis;
cpc_pkg::data_t       m_rom_sel;      // Also seen on o_led
cpc_pkg::data_t       m_ppi_a;
cpc_pkg::data_t       m_ppi_c;
cpc_pkg::data_t       m_ppi_ctrl;
logic [4:0]           m_crtc_idx;
cpc_pkg::scr_start_t  m_scr;
cpc_pkg::data_t       m_ctrl;         // Host control, bit 1 load

function automatic void model_reset();
  m_pen        = '0;
  m_border_sel = 1'b0;
  m_border     = '0;
  m_mode       = '0;
  m_lo_dis     = 1'b0;
  m_hi_dis     = 1'b0;
  m_rom_sel    = '0;
  m_ppi_a      = '0;
  m_ppi_c      = '0;
  m_ppi_ctrl   = '0;
  m_crtc_idx   = '0;
  m_scr        = '0;
  m_ctrl       = '0;
  for (int i = 0; i < 16; i++) begin
    m_palette[i] = '0;
  end
endfunction

// Every IO write seen by gate array, ROM select and ports alike
function automatic void model_io_write(cpc_pkg::addr_t a, cpc_pkg::data_t d);
  if (a[15:14] == 2'b01) begin
    case (cpc_pkg::ga_cmd_e'(d[7:6]))
      cpc_pkg::GA_INK_SEL: begin
        m_border_sel = d[4];
        if (!d[4]) m_pen = d[3:0];  // Pen only when border not picked
      end
      cpc_pkg::GA_PALETTE: begin
        if (m_border_sel) m_border = d[4:0];
        else m_palette[m_pen] = d[4:0];
      end
      cpc_pkg::GA_MODE_ROM: begin
        m_hi_dis = d[3];
        m_lo_dis = d[2];
        m_mode   = d[1:0];
      end
      default: ;  // RAM config ignored
    endcase
  end else if (!a[13]) begin
    m_rom_sel = d;
  end
  case (a[15:8])
    cpc_pkg::PPI_A_HI:    m_ppi_a    = d;
    cpc_pkg::PPI_C_HI:    m_ppi_c    = d;
    cpc_pkg::PPI_CTRL_HI: m_ppi_ctrl = d;
    cpc_pkg::CRTC_SEL_HI: m_crtc_idx = d[4:0];
    cpc_pkg::CRTC_DATA_HI: begin
      if (m_crtc_idx == 5'd12) m_scr[9:8] = d[1:0];
      if (m_crtc_idx == 5'd13) m_scr[7:0] = d;
    end
    default: ;
  endcase
endfunction

function automatic void model_host_write(logic [23:0] ha, cpc_pkg::data_t d);
  case (ha[23:16])
    8'h00:   m_ram[ha[15:0]] = d;
    8'h01:   m_rom[ha[15:0]] = d;
    8'hFF:   m_ctrl = d;
    default: ;  // Unknown region, no effect
  endcase
endfunction

// CPU write lands in RAM only outside load mode
function automatic void model_cpu_write(cpc_pkg::addr_t a, cpc_pkg::data_t d);
  if (!m_ctrl[1]) m_ram[a] = d;
endfunction

function automatic cpc_pkg::data_t model_mem_read(cpc_pkg::addr_t a);
  logic [1:0] bank;
  bank = (m_rom_sel == 8'(basic_rom_bank)) ? 2'd2 : 2'd1;  // BASIC or bank 1
  case (a[15:14])
    2'b00:   return m_lo_dis ? m_ram[a] : m_rom[{2'b00, a[13:0]}];
    2'b11:   return m_hi_dis ? m_ram[a] : m_rom[{bank, a[13:0]}];
    default: return m_ram[a];
  endcase
endfunction

// Port B, 1E with vsync inverted on bit 0
function automatic cpc_pkg::data_t model_io_read(cpc_pkg::addr_t a, logic vsync);
  if (a[15:8] == 8'hF5) return {7'b0001111, !vsync};
  return 8'h00;
endfunction

`endif

// File: verif/tb_cpc.sv
module tb_cpc;

  localparam int unsigned basic_rom_bank = 7;
  localparam int n_load  = 24;  // Load entries, five writes each
  localparam int n_read  = 40;
  localparam int n_ramwr = 24;
  localparam int n_ga    = 48;
  localparam int n_io    = 40;
  localparam int total_ops = 20 + n_load * 6 + n_read * 3 + n_ramwr * 3 +
                             n_ga + (n_ga / 8) * 16 + n_io * 3;
  localparam longint watchdog_time = 2 * total_ops * 4 * 20;

  logic                 clk_cpu;
  logic                 pwr_up_reset_n;
  cpc_pkg::addr_t       i_addr;
  cpc_pkg::data_t       i_data;
  logic                 i_mreq_n;
  logic                 i_iorq_n;
  logic                 i_rd_n;
  logic                 i_wr_n;
  cpc_pkg::data_t       o_data;
  logic                 o_wait_n;
  logic                 o_cpu_reset_n;
  logic                 i_host_wr;
  logic [23:0]          i_host_addr;
  cpc_pkg::data_t       i_host_data;
  logic                 i_vsync;
  cpc_pkg::pen_t        i_pen_lookup;
  cpc_pkg::color_t      o_color;
  cpc_pkg::color_t      o_border;
  cpc_pkg::video_mode_t o_mode;
  cpc_pkg::data_t       o_ppi_a;
  cpc_pkg::data_t       o_ppi_c;
  cpc_pkg::data_t       o_ppi_ctrl;
  cpc_pkg::scr_start_t  o_scr_start;
  cpc_pkg::data_t       o_led;

  logic [31:0]    lfsr;       // Stimulus generator state
  cpc_pkg::addr_t addr_q[$];  // Offsets loaded by the host

  `include "cpc_model.svh"

  cpc_core #(.c_basic_rom_bank(basic_rom_bank)) dut0 (
    .clk_cpu, .pwr_up_reset_n, .i_addr, .i_data, .i_mreq_n, .i_iorq_n,
    .i_rd_n, .i_wr_n, .o_data, .o_wait_n, .o_cpu_reset_n,
    .i_host_wr, .i_host_addr, .i_host_data, .i_vsync, .i_pen_lookup,
    .o_color, .o_border, .o_mode, .o_ppi_a, .o_ppi_c, .o_ppi_ctrl,
    .o_scr_start, .o_led
  );

  initial begin
    clk_cpu = 1'b0;
    forever #10 clk_cpu = ~clk_cpu;  // Period 20
  end

  // ====================
  // Random numbers
  // ====================
  function automatic logic [31:0] galois_step(logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = galois_step(lfsr);
      r = {r[30:0], lfsr[0]};
    end
    return r;
  endfunction

  // ====================
  // Compare tasks
  // ====================
  task automatic stop_with_failure();
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_data(string name, cpc_pkg::data_t got, cpc_pkg::data_t exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_color(string name, cpc_pkg::color_t got, cpc_pkg::color_t exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_mode(string name, cpc_pkg::video_mode_t got,
                            cpc_pkg::video_mode_t exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_scr(string name, cpc_pkg::scr_start_t got,
                           cpc_pkg::scr_start_t exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  task automatic check_level(string name, logic got, logic exp);
    if (got !== exp) begin
      $display("FAILED %s got %h expected %h", name, got, exp);
      stop_with_failure();
    end
  endtask

  // ====================
  // Bus cycles
  // ====================
  task automatic release_bus();
    i_mreq_n  = 1'b1;
    i_iorq_n  = 1'b1;
    i_rd_n    = 1'b1;
    i_wr_n    = 1'b1;
    i_host_wr = 1'b0;
  endtask

  task automatic io_write(cpc_pkg::addr_t a, cpc_pkg::data_t d);
    @(negedge clk_cpu);
    i_addr   = a;
    i_data   = d;
    i_iorq_n = 1'b0;
    i_wr_n   = 1'b0;
    model_io_write(a, d);
    @(negedge clk_cpu);
    release_bus();
  endtask

  task automatic mem_write(cpc_pkg::addr_t a, cpc_pkg::data_t d);
    @(negedge clk_cpu);
    i_addr   = a;
    i_data   = d;
    i_mreq_n = 1'b0;
    i_wr_n   = 1'b0;
    model_cpu_write(a, d);  // Dropped in load mode
    @(negedge clk_cpu);
    release_bus();
  endtask

  task automatic host_write(logic [23:0] ha, cpc_pkg::data_t d);
    @(negedge clk_cpu);
    i_host_addr = ha;
    i_host_data = d;
    i_host_wr   = 1'b1;  // Single cycle pulse
    model_host_write(ha, d);
    @(negedge clk_cpu);
    release_bus();
  endtask

  task automatic mem_read_check(cpc_pkg::addr_t a);
    cpc_pkg::data_t exp;
    exp = model_mem_read(a);
    @(negedge clk_cpu);
    i_addr   = a;
    i_mreq_n = 1'b0;
    i_rd_n   = 1'b0;
    repeat (2) @(negedge clk_cpu);  // Strobes held over two edges
    check_data($sformatf("o_data @%h", a), o_data, exp);
    release_bus();
  endtask

  task automatic io_read_check(cpc_pkg::addr_t a, logic vsync);
    @(negedge clk_cpu);
    i_addr   = a;
    i_vsync  = vsync;
    i_iorq_n = 1'b0;
    i_rd_n   = 1'b0;
    repeat (2) @(negedge clk_cpu);
    check_data($sformatf("o_data io %h", a), o_data, model_io_read(a, vsync));
    release_bus();
  endtask

  task automatic check_host_levels();
    check_level("o_wait_n", o_wait_n, !m_ctrl[1]);
    check_level("o_cpu_reset_n", o_cpu_reset_n, !m_ctrl[0]);
  endtask

  task automatic sweep_pens();
    for (int p = 0; p < 16; p++) begin
      @(negedge clk_cpu);
      i_pen_lookup = 4'(p);
      @(negedge clk_cpu);
      check_color($sformatf("o_color pen %0d", p), o_color, m_palette[p]);
    end
  endtask

  // ====================
  // Test phases
  // ====================
  task automatic run_host_ctrl();
    cpc_pkg::data_t vals [4] = '{8'h02, 8'h01, 8'h03, 8'h00};
    foreach (vals[i]) begin
      host_write({8'hFF, 16'(rand_bits(16))}, vals[i]);
      check_host_levels();
    end
  endtask

  task automatic run_load_and_read();
    cpc_pkg::addr_t off;
    cpc_pkg::data_t sel;
    int             idx;
    host_write(24'hFF0000, 8'h02);  // Enter load mode
    for (int i = 0; i < n_load; i++) begin
      off = 16'(rand_bits(16));
      addr_q.push_back(off);
      host_write({8'h00, off}, 8'(rand_bits(8)));
      for (int b = 0; b < 3; b++) begin
        host_write({8'h01, 2'(b), off[13:0]}, 8'(rand_bits(8)));  // Banks 0..2
      end
      mem_write(off, 8'(rand_bits(8)));
      check_level("o_wait_n", o_wait_n, 1'b0);
    end
    host_write(24'hFF0000, 8'h00);
    check_host_levels();
    for (int i = 0; i < n_read; i++) begin
      io_write(16'h7F00, {4'b1000, 4'(rand_bits(4))});  // ROM disables and mode
      sel = rand_bits(1) ? cpc_pkg::data_t'(basic_rom_bank) : 8'(rand_bits(8));
      io_write(16'hDF00, sel);
      check_data("o_led", o_led, m_rom_sel);
      check_mode("o_mode", o_mode, m_mode);
      idx = int'(rand_bits(5)) % addr_q.size();
      mem_read_check(addr_q[idx]);
    end
  endtask

  task automatic run_ram_writes();
    cpc_pkg::addr_t off;
    int             idx;
    for (int i = 0; i < n_ramwr; i++) begin
      idx = int'(rand_bits(5)) % addr_q.size();
      off = addr_q[idx];
      mem_write(off, 8'(rand_bits(8)));
      io_write(16'h7F00, {4'b1000, 4'(rand_bits(4))});
      mem_read_check(off);  // RAM wherever ROM is off
    end
  endtask

  task automatic run_gate_array();
    for (int i = 0; i < n_ga; i++) begin
      io_write({2'b01, 6'(rand_bits(6)), 8'(rand_bits(8))}, 8'(rand_bits(8)));
      check_color("o_border", o_border, m_border);
      check_mode("o_mode", o_mode, m_mode);
      if (i % 8 == 7) sweep_pens();
    end
  endtask

  task automatic run_io_ports();
    cpc_pkg::data_t hi;
    cpc_pkg::data_t d;
    for (int i = 0; i < n_io; i++) begin
      case (int'(rand_bits(3)) % 5)
        0:       hi = 8'hF4;
        1:       hi = 8'hF6;
        2:       hi = 8'hF7;
        3:       hi = 8'hBC;
        default: hi = 8'hBD;
      endcase
      d = 8'(rand_bits(8));
      if (hi == 8'hBC && rand_bits(1)) d[4:0] = rand_bits(1) ? 5'd12 : 5'd13;  // Bias
      io_write({hi, 8'(rand_bits(8))}, d);
      check_data("o_ppi_a", o_ppi_a, m_ppi_a);
      check_data("o_ppi_c", o_ppi_c, m_ppi_c);
      check_data("o_ppi_ctrl", o_ppi_ctrl, m_ppi_ctrl);
      check_scr("o_scr_start", o_scr_start, m_scr);
      io_read_check({8'hF5, 8'(rand_bits(8))}, rand_bits(1));
      hi = 8'(rand_bits(8));
      if (hi == 8'hF5) hi = 8'hF4;  // Anything but port B
      io_read_check({hi, 8'(rand_bits(8))}, rand_bits(1));
    end
  endtask

  // Watchdog
  initial begin
    #(watchdog_time);
    $display("Run timed out after %0d time units", watchdog_time);
    stop_with_failure();
  end

  initial begin
    pwr_up_reset_n = 1'b0;
    i_addr         = '0;
    i_data         = '0;
    i_host_addr    = '0;
    i_host_data    = '0;
    i_vsync        = 1'b0;
    i_pen_lookup   = '0;
    release_bus();
    lfsr = 32'h9921;
    model_reset();
    repeat (3) @(posedge clk_cpu);
    @(negedge clk_cpu);
    check_level("o_cpu_reset_n", o_cpu_reset_n, 1'b0);  // Held during reset
    pwr_up_reset_n = 1'b1;
    @(negedge clk_cpu);
    check_host_levels();
    check_data("o_data", o_data, 8'h00);
    check_data("o_led", o_led, 8'h00);
    check_mode("o_mode", o_mode, 2'd0);
    check_scr("o_scr_start", o_scr_start, 10'd0);
    run_host_ctrl();
    run_load_and_read();
    run_ram_writes();
    run_gate_array();
    run_io_ports();
    $display("TEST PASSED");
    $finish;
  end

endmodule

// File: build.f
+incdir+verif
logic/cpc_pkg.sv
logic/gate_array.sv
logic/io_ports.sv
logic/mem_arbiter.sv
logic/memory_map.sv
logic/cpc_core.sv
verif/tb_cpc.sv
